/* board_top.sv */
// board glue top level
`timescale 1ns/1ps

module board_top import mg_pkg::*; #(
	parameter logic [region_w-1:0] WORK_REGION = 8'h01,
	parameter logic [region_w-1:0] VRAM_REGION = 8'h00
) (
	input  logic                   CLK54,
	input  logic                   RST_N,
	// cartridge
	input  logic                   cart_req,
	input  logic [cart_addr_w-1:0] cart_addr,
	output logic                   cart_ack,
	output logic [data_w-1:0]      cart_rdata,
	// work ram
	input  logic                   work_req,
	input  logic                   work_we,
	input  logic [word_addr_w-1:0] work_addr,
	input  logic [be_w-1:0]        work_be,
	input  logic [data_w-1:0]      work_wdata,
	output logic                   work_ack,
	output logic [data_w-1:0]      work_rdata,
	// video ram
	input  logic                   vram_req,
	input  logic                   vram_we,
	input  logic [word_addr_w-1:0] vram_addr,
	input  logic [be_w-1:0]        vram_be,
	input  logic [data_w-1:0]      vram_wdata,
	output logic                   vram_ack,
	output logic [data_w-1:0]      vram_rdata,
	// memory controller channel
	output logic                   mem_cmd_req,
	output mem_instr_e             mem_cmd_instr,
	output logic [mem_addr_w-1:0]  mem_cmd_addr,
	output logic [be_w-1:0]        mem_wr_mask,
	output logic [data_w-1:0]      mem_wr_data,
	input  logic                   mem_cmd_ack,
	input  logic [data_w-1:0]      mem_rd_data,
	input  logic                   mem_rd_ack,
	input  logic                   mem_wr_ack,
	// console video in, connector out
	input  logic                   pix_clk,
	input  logic [pix_w-1:0]       pix_r,
	input  logic [pix_w-1:0]       pix_g,
	input  logic [pix_w-1:0]       pix_b,
	input  logic                   pix_hs,
	input  logic                   pix_vs,
	input  logic                   pix_de,
	output logic [red_w-1:0]       video_red,
	output logic [grn_w-1:0]       video_grn,
	output logic [blu_w-1:0]       video_blu,
	output logic                   video_hsync,
	output logic                   video_vsync,
	// audio meter
	input  logic [audio_w-1:0]     audio_l,
	input  logic [audio_w-1:0]     audio_r,
	input  logic                   led_sel,
	output logic [led_w-1:0]       led
);

	mem_port_if work_if ();	// work ram bundle
	mem_port_if vram_if ();	// video ram bundle

	// ----------------------------------------
	// client ports into bundles
	// ----------------------------------------
	assign work_if.req   = work_req;
	assign work_if.we    = work_we;
	assign work_if.addr  = work_addr;
	assign work_if.be    = work_be;
	assign work_if.wdata = work_wdata;
	assign work_ack      = work_if.ack;
	assign work_rdata    = work_if.rdata;

	assign vram_if.req   = vram_req;
	assign vram_if.we    = vram_we;
	assign vram_if.addr  = vram_addr;
	assign vram_if.be    = vram_be;
	assign vram_if.wdata = vram_wdata;
	assign vram_ack      = vram_if.ack;
	assign vram_rdata    = vram_if.rdata;

	mem_arbiter #(
		.WORK_REGION(WORK_REGION),
		.VRAM_REGION(VRAM_REGION)
	) mem_arbiter_i (
		.CLK54(CLK54), .RST_N(RST_N),
		.cart_req(cart_req), .cart_addr(cart_addr),
		.cart_ack(cart_ack), .cart_rdata(cart_rdata),
		.work(work_if.arbiter), .vram(vram_if.arbiter),
		.mem_cmd_req(mem_cmd_req), .mem_cmd_instr(mem_cmd_instr),
		.mem_cmd_addr(mem_cmd_addr), .mem_wr_mask(mem_wr_mask),
		.mem_wr_data(mem_wr_data), .mem_cmd_ack(mem_cmd_ack),
		.mem_rd_data(mem_rd_data), .mem_rd_ack(mem_rd_ack),
		.mem_wr_ack(mem_wr_ack)
	);

	video_sampler video_sampler_i (
		.CLK54(CLK54), .RST_N(RST_N),
		.pix_clk(pix_clk), .pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b),
		.pix_hs(pix_hs), .pix_vs(pix_vs), .pix_de(pix_de),
		.video_red(video_red), .video_grn(video_grn), .video_blu(video_blu),
		.video_hsync(video_hsync), .video_vsync(video_vsync)
	);

	level_meter level_meter_i (
		.CLK54(CLK54), .RST_N(RST_N),
		.audio_l(audio_l), .audio_r(audio_r),
		.led_sel(led_sel), .led(led)	// switch picks channel
	);

endmodule

/* board_top_props.sv */
// memory handshake properties
`timescale 1ns/1ps

module board_top_props import mg_pkg::*; (
	input logic                  CLK54,
	input logic                  RST_N,
	input logic                  mem_cmd_req,
	input logic                  mem_cmd_ack,
	input logic [3:0]            mem_cmd_instr,
	input logic [mem_addr_w-1:0] mem_cmd_addr,
	input logic [be_w-1:0]       mem_wr_mask,
	input logic [data_w-1:0]     mem_wr_data,
	input logic [n_ports-1:0]    client_ack	// one bit per client
);

	// command frozen until the memory takes it
	assert property (@(posedge CLK54) disable iff (!RST_N)
		(mem_cmd_req && !mem_cmd_ack) |=> (mem_cmd_req &&
		$stable({mem_cmd_instr, mem_cmd_addr, mem_wr_mask, mem_wr_data})))
		else $error("memory command changed before cmd ack");

	assert property (@(posedge CLK54) disable iff (!RST_N)
		(client_ack != '0) |=> (client_ack == '0))
		else $error("client ack longer than one cycle");

	assert property (@(posedge CLK54) $onehot0(client_ack))
		else $error("more than one client ack at once");

endmodule

bind mem_arbiter board_top_props board_top_props_i (
	.CLK54(CLK54),
	.RST_N(RST_N),
	.mem_cmd_req(mem_cmd_req),
	.mem_cmd_ack(mem_cmd_ack),
	.mem_cmd_instr(mem_cmd_instr),
	.mem_cmd_addr(mem_cmd_addr),
	.mem_wr_mask(mem_wr_mask),
	.mem_wr_data(mem_wr_data),
	.client_ack(ack_r)
);

/* level_meter.sv */
// audio level bar
`timescale 1ns/1ps

module level_meter import mg_pkg::*; (
	input  logic               CLK54,
	input  logic               RST_N,
	input  logic [audio_w-1:0] audio_l,
	input  logic [audio_w-1:0] audio_r,
	input  logic               led_sel,	// 0 = left, 1 = right
	output logic [led_w-1:0]   led
);

	logic [7:0]       level_q;	// upper byte of chosen channel
	logic [7:0]       mag;	// folded magnitude
	logic [2:0]       cnt;	// lit led count
	logic [led_w-1:0] bar;

	// ----------------------------------------
	// sample stage
	// ----------------------------------------
	always_ff @(posedge CLK54 or negedge RST_N)
	begin
		if (!RST_N)
		begin
			level_q <= '0;
			led     <= '0;
		end
		else
		begin
			level_q <= led_sel ? audio_r[audio_w-1 -: 8] : audio_l[audio_w-1 -: 8];
			led     <= bar;	// second stage
		end
	end

	// negative samples fold by inversion, not negation
	assign mag = level_q[7] ? {~level_q[6:0], 1'b0} : {level_q[6:0], 1'b0};
	assign cnt = mag[7:5];

	always_comb
	begin
		bar = '0;	// top led stays dark
		for (int i = 0; i < led_w - 1; i++)
			bar[i] = (i < cnt);	// thermometer
	end

endmodule

/* mem_arbiter.sv */
// memory arbiter and address mapper
`timescale 1ns/1ps

module mem_arbiter import mg_pkg::*; #(
	parameter logic [region_w-1:0] WORK_REGION = 8'h01,	// work ram region byte
	parameter logic [region_w-1:0] VRAM_REGION = 8'h00	// video ram region byte
) (
	input  logic                   CLK54,
	input  logic                   RST_N,
	input  logic                   cart_req,	// cartridge, read only
	input  logic [cart_addr_w-1:0] cart_addr,
	output logic                   cart_ack,
	output logic [data_w-1:0]      cart_rdata,
	mem_port_if.arbiter            work,	// work ram client
	mem_port_if.arbiter            vram,	// video ram client
	output logic                   mem_cmd_req,
	output mem_instr_e             mem_cmd_instr,
	output logic [mem_addr_w-1:0]  mem_cmd_addr,
	output logic [be_w-1:0]        mem_wr_mask,	// 1 = byte kept
	output logic [data_w-1:0]      mem_wr_data,
	input  logic                   mem_cmd_ack,
	input  logic [data_w-1:0]      mem_rd_data,
	input  logic                   mem_rd_ack,
	input  logic                   mem_wr_ack
);

	// ram byte address: zeros, region, word address, byte lane zeros
	function automatic logic [mem_addr_w-1:0] ram_byte_addr(
		input logic [region_w-1:0]    region,
		input logic [word_addr_w-1:0] waddr
	);
		ram_byte_addr = {{(mem_addr_w-region_w-word_addr_w-2){1'b0}}, region, waddr, 2'b00};
	endfunction

	arb_state_e             state_r;
	port_id_e               grant_r;	// port owning the transaction
	logic                   cmd_req_r;
	logic [n_ports-1:0]     ack_r;	// one-hot client ack
	mem_instr_e             cmd_instr_r;
	logic [mem_addr_w-1:0]  cmd_addr_r;
	logic [be_w-1:0]        cmd_mask_r;
	logic [data_w-1:0]      cmd_wdata_r;
	logic [data_w-1:0]      rdata_r;	// read word for the client

	logic                   sel_valid;
	port_id_e               sel_port;
	mem_instr_e             sel_instr;
	logic [mem_addr_w-1:0]  sel_addr;
	logic [be_w-1:0]        sel_mask;
	logic [data_w-1:0]      sel_wdata;
	logic                   grant_go;

	// ----------------------------------------
	// fixed priority select and translation
	// ----------------------------------------
	always_comb
	begin
		sel_valid = 1'b1;
		if (cart_req)
			sel_port = port_cart;	// cart wins
		else if (work.req)
			sel_port = port_work;
		else if (vram.req)
			sel_port = port_vram;
		else
		begin
			sel_port  = port_cart;
			sel_valid = 1'b0;	// nobody asking
		end
	end

	always_comb
	begin
		case (sel_port)
			port_work:
			begin
				sel_instr = work.we ? mem_wr : mem_rd;
				sel_addr  = ram_byte_addr(WORK_REGION, work.addr);
				sel_mask  = ~work.be;	// mask is inverse of be
				sel_wdata = work.wdata;
			end
			port_vram:
			begin
				sel_instr = vram.we ? mem_wr : mem_rd;
				sel_addr  = ram_byte_addr(VRAM_REGION, vram.addr);
				sel_mask  = ~vram.be;
				sel_wdata = vram.wdata;
			end
			default:
			begin
				sel_instr = flash_rd;	// cartridge lives in flash
				sel_addr  = {{(mem_addr_w-cart_addr_w-1){1'b0}}, cart_addr, 1'b0};
				sel_mask  = '0;
				sel_wdata = '0;
			end
		endcase
	end

	// no new grant while the previous ack is still out
	assign grant_go = (state_r == arb_idle) && sel_valid && (ack_r == '0);

	// ----------------------------------------
	// transaction FSM
	// ----------------------------------------
	always_ff @(posedge CLK54 or negedge RST_N)
	begin
		if (!RST_N)
		begin
			state_r   <= arb_idle;
			grant_r   <= port_cart;
			cmd_req_r <= 1'b0;
			ack_r     <= '0;
		end
		else
		begin
			ack_r <= '0;	// ack is a single pulse
			case (state_r)
				arb_idle:
					if (grant_go)
					begin
						grant_r <= sel_port;
						state_r <= arb_cmd;
					end
				arb_cmd:
					if (!cmd_req_r)
						cmd_req_r <= 1'b1;	// raise one edge after grant
					else if (mem_cmd_ack)
					begin
						cmd_req_r <= 1'b0;
						state_r   <= (cmd_instr_r == mem_wr) ? arb_wait_wr : arb_wait_rd;
					end
				arb_wait_rd:
					if (mem_rd_ack)
						state_r <= arb_done;
				arb_wait_wr:
					if (mem_wr_ack)
						state_r <= arb_done;
				arb_done:
				begin
					ack_r[grant_r] <= 1'b1;	// client ack one edge after completion
					state_r        <= arb_idle;
				end
				default:
					state_r <= arb_idle;
			endcase
		end
	end

	// command and read data, frozen for the whole transaction
	always_ff @(posedge CLK54)
	begin
		if (grant_go)
		begin
			cmd_instr_r <= sel_instr;
			cmd_addr_r  <= sel_addr;
			cmd_mask_r  <= sel_mask;
			cmd_wdata_r <= sel_wdata;
		end
		if ((state_r == arb_wait_rd) && mem_rd_ack)
			rdata_r <= mem_rd_data;	// memory data valid only in rd ack cycle
	end

	// ----------------------------------------
	// memory channel and client returns
	// ----------------------------------------
	assign mem_cmd_req   = cmd_req_r;
	assign mem_cmd_instr = cmd_instr_r;
	assign mem_cmd_addr  = cmd_addr_r;
	assign mem_wr_mask   = cmd_mask_r;
	assign mem_wr_data   = cmd_wdata_r;

	assign cart_ack   = ack_r[port_cart];
	assign cart_rdata = (grant_r == port_cart) ? rdata_r : '0;	// granted port only
	assign work.ack   = ack_r[port_work];
	assign work.rdata = (grant_r == port_work) ? rdata_r : '0;
	assign vram.ack   = ack_r[port_vram];
	assign vram.rdata = (grant_r == port_vram) ? rdata_r : '0;

endmodule

/* mem_port_if.sv */
// memory client port
`timescale 1ns/1ps

interface mem_port_if import mg_pkg::*; ();

	logic                   req;	// held until ack
	logic                   we;	// 1 = write
	logic [word_addr_w-1:0] addr;	// word address
	logic [be_w-1:0]        be;	// byte enables, active high
	logic [data_w-1:0]      wdata;
	logic                   ack;	// one cycle, rdata valid here
	logic [data_w-1:0]      rdata;

	// console side
	modport client (
		output req, we, addr, be, wdata,
		input  ack, rdata
	);

	// arbiter side
	modport arbiter (
		input  req, we, addr, be, wdata,
		output ack, rdata
	);

endinterface

/* mg_pkg.sv */
// board glue shared definitions
package mg_pkg;

	// ----------------------------------------
	// memory channel widths
	// ----------------------------------------
	localparam int data_w      = 32;	// memory data bus
	localparam int be_w        = data_w / 8;	// byte enables per word
	localparam int word_addr_w = 14;	// client word address, byte addr [15:2]
	localparam int cart_addr_w = 21;	// cartridge halfword address
	localparam int mem_addr_w  = 30;	// board memory byte address
	localparam int region_w    = 8;	// region byte, lands on byte addr [23:16]
	localparam int n_ports     = 3;	// cart, work, vram

	// ----------------------------------------
	// video and audio widths
	// ----------------------------------------
	localparam int pix_w   = 8;	// console colour per channel
	localparam int red_w   = 3;	// connector red
	localparam int grn_w   = 3;	// connector green
	localparam int blu_w   = 2;	// connector blue
	localparam int audio_w = 16;	// signed audio sample
	localparam int led_w   = 8;	// led bar

	// memory opcode, bit 3 picks the flash device
	typedef enum logic [3:0] {
		mem_wr   = 4'b0000,	// ram write
		mem_rd   = 4'b0001,	// ram read
		flash_rd = 4'b1001	// flash read
	} mem_instr_e;

	typedef enum logic [2:0] {
		arb_idle,	// waiting for a client
		arb_cmd,	// command out, waiting for cmd ack
		arb_wait_rd,	// waiting for rd ack
		arb_wait_wr,	// waiting for wr ack
		arb_done	// completion seen, ack next
	} arb_state_e;

	typedef enum logic [1:0] {
		port_cart = 2'd0,	// highest priority
		port_work = 2'd1,
		port_vram = 2'd2
	} port_id_e;

endpackage

/* project.f */
mg_pkg.sv
mem_port_if.sv
mem_arbiter.sv
video_sampler.sv
level_meter.sv
board_top.sv
board_top_props.sv
tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the board glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_board_top -o sim_board
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_board > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

/* tb_board_top.sv */
// board glue testbench
`timescale 1ns/1ps

module tb_board_top import mg_pkg::*; ();

	localparam int timeout_cyc = 200;	// cycles per wait
	localparam logic [7:0] work_region_ref = 8'h01;
	localparam logic [7:0] vram_region_ref = 8'h00;

	logic                   CLK54;
	logic                   RST_N;
	logic                   cart_req;
	logic [cart_addr_w-1:0] cart_addr;
	logic                   cart_ack;
	logic [data_w-1:0]      cart_rdata;
	logic                   work_req;
	logic                   work_we;
	logic [word_addr_w-1:0] work_addr;
	logic [be_w-1:0]        work_be;
	logic [data_w-1:0]      work_wdata;
	logic                   work_ack;
	logic [data_w-1:0]      work_rdata;
	logic                   vram_req;
	logic                   vram_we;
	logic [word_addr_w-1:0] vram_addr;
	logic [be_w-1:0]        vram_be;
	logic [data_w-1:0]      vram_wdata;
	logic                   vram_ack;
	logic [data_w-1:0]      vram_rdata;
	logic                   mem_cmd_req;
	mem_instr_e             mem_cmd_instr;
	logic [mem_addr_w-1:0]  mem_cmd_addr;
	logic [be_w-1:0]        mem_wr_mask;
	logic [data_w-1:0]      mem_wr_data;
	logic                   mem_cmd_ack;
	logic [data_w-1:0]      mem_rd_data;
	logic                   mem_rd_ack;
	logic                   mem_wr_ack;
	logic                   pix_clk;
	logic [pix_w-1:0]       pix_r;
	logic [pix_w-1:0]       pix_g;
	logic [pix_w-1:0]       pix_b;
	logic                   pix_hs;
	logic                   pix_vs;
	logic                   pix_de;
	logic [red_w-1:0]       video_red;
	logic [grn_w-1:0]       video_grn;
	logic [blu_w-1:0]       video_blu;
	logic                   video_hsync;
	logic                   video_vsync;
	logic [audio_w-1:0]     audio_l;
	logic [audio_w-1:0]     audio_r;
	logic                   led_sel;
	logic [led_w-1:0]       led;

	logic [data_w-1:0] ram [logic [mem_addr_w-1:0]];	// written ram words by byte addr
	logic [37:0]       exp_cmd [$];	// {instr, addr, mask} in grant order
	port_id_e          ack_order [$];	// clients in ack order
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int err_mark;	// error count at test start

	board_top board_top_i (.*);

	always #4 CLK54 = ~CLK54;	// 8 ns period

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [37:0] mem_addr_ref(input port_id_e p, input logic we,
		input logic [cart_addr_w-1:0] a, input logic [be_w-1:0] be);
		logic [mem_addr_w-1:0] addr;
		logic [3:0]            instr;
		logic [be_w-1:0]       mask;
		if (p == port_cart)
		begin
			addr  = {8'd0, a, 1'b0};	// halfword to byte address
			instr = 4'b1001;
			mask  = 4'b0000;
		end
		else
		begin
			addr  = {6'd0, (p == port_work) ? work_region_ref : vram_region_ref, a[13:0], 2'b00};
			instr = we ? 4'b0000 : 4'b0001;
			mask  = ~be;	// mask keeps disabled bytes
		end
		mem_addr_ref = {instr, addr, mask};
	endfunction

	// unwritten contents hashed from every address bit
	function automatic logic [data_w-1:0] fill_word(input logic [mem_addr_w-1:0] a,
		input logic flash);
		fill_word = ({2'b00, a} * 32'h9e37_79b1) ^ (flash ? 32'hc3a5_5a3c : 32'h1f2e_3d4c);
	endfunction

	function automatic logic [data_w-1:0] byte_merge(input logic [data_w-1:0] old_w,
		input logic [data_w-1:0] nw, input logic [be_w-1:0] take);
		byte_merge = old_w;
		for (int i = 0; i < be_w; i++)
			if (take[i])
				byte_merge[8*i +: 8] = nw[8*i +: 8];
	endfunction

	function automatic logic [9:0] pixel_ref(input logic [7:0] r, input logic [7:0] g,
		input logic [7:0] b, input logic hs, input logic vs, input logic de);
		pixel_ref = de ? {r[7:5], g[7:5], b[7:6], hs, vs} : {8'd0, hs, vs};	// blank colour only
	endfunction

	function automatic logic [7:0] led_ref(input logic [15:0] l, input logic [15:0] r,
		input logic sel);
		logic [7:0] s;
		logic [7:0] m;
		s = sel ? r[15:8] : l[15:8];
		m = s[7] ? {~s[6:0], 1'b0} : {s[6:0], 1'b0};	// ones-complement fold
		led_ref = '0;
		for (int i = 0; i < 7; i++)
			led_ref[i] = (i < int'(m[7:5]));
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic test_done(input string name);
		tests_run++;
		if (errors != err_mark)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "failed");
		err_mark = errors;
	endtask

	// ----------------------------------------
	// memory controller model and command compare
	// ----------------------------------------
	always
	begin : mem_model
		logic [mem_addr_w-1:0] a;
		logic [be_w-1:0]       m;
		logic [data_w-1:0]     wd;
		logic [data_w-1:0]     old_w;
		logic                  flash;
		logic                  wr;
		int n;
		@(posedge CLK54);
		#1;
		if (RST_N && mem_cmd_req)
		begin
			if (exp_cmd.size() == 0)
			begin
				errors++;
				$display("memory command at %0t with no client request outstanding", $time);
			end
			else
				check("mem command", {mem_cmd_instr, mem_cmd_addr, mem_wr_mask}, exp_cmd.pop_front());
			a     = mem_cmd_addr;
			m     = mem_wr_mask;
			wd    = mem_wr_data;
			flash = mem_cmd_instr[3];
			wr    = (mem_cmd_instr == mem_wr);
			n     = $urandom_range(0, 5);	// idle cycles before cmd ack
			repeat (n)
			begin
				@(posedge CLK54);
				#1;
			end
			mem_cmd_ack = 1'b1;
			@(posedge CLK54);
			#1;
			mem_cmd_ack = 1'b0;
			n = $urandom_range(0, 5);	// completion 1 to 6 after cmd ack
			repeat (n)
			begin
				@(posedge CLK54);
				#1;
			end
			old_w = ram.exists(a) ? ram[a] : fill_word(a, 1'b0);
			if (wr)
			begin
				ram[a]     = byte_merge(old_w, wd, ~m);	// mask bit set keeps old byte
				mem_wr_ack = 1'b1;
			end
			else
			begin
				mem_rd_data = flash ? fill_word(a, 1'b1) : old_w;
				mem_rd_ack  = 1'b1;
			end
			@(posedge CLK54);
			#1;
			mem_wr_ack  = 1'b0;
			mem_rd_ack  = 1'b0;
			mem_rd_data = $urandom();	// junk outside the ack cycle
		end
	end

	// ----------------------------------------
	// client side
	// ----------------------------------------
	task automatic do_req(input port_id_e p, input logic we, input logic [cart_addr_w-1:0] a,
		input logic [be_w-1:0] be, input logic [data_w-1:0] wd, output logic [data_w-1:0] rd);
		int  n;
		logic seen;
		case (p)
			port_cart:
			begin
				cart_addr = a;
				cart_req  = 1'b1;
			end
			port_work:
			begin
				{work_we, work_addr, work_be, work_wdata} = {we, a[13:0], be, wd};
				work_req = 1'b1;
			end
			default:
			begin
				{vram_we, vram_addr, vram_be, vram_wdata} = {we, a[13:0], be, wd};
				vram_req = 1'b1;
			end
		endcase
		n    = 0;
		seen = 1'b0;
		while (!seen && n < timeout_cyc)
		begin
			@(posedge CLK54);
			#1;
			n++;
			case (p)
				port_cart: {seen, rd} = {cart_ack, cart_rdata};
				port_work: {seen, rd} = {work_ack, work_rdata};
				default:   {seen, rd} = {vram_ack, vram_rdata};
			endcase
		end
		case (p)	// drop req in the cycle after ack
			port_cart: cart_req = 1'b0;
			port_work: work_req = 1'b0;
			default:   vram_req = 1'b0;
		endcase
		if (seen)
			ack_order.push_back(p);
		else
		begin
			errors++;
			$display("timeout: client %0d got no ack within %0d cycles", p, timeout_cyc);
		end
	endtask

	task automatic issue(input port_id_e p, input logic we, input logic [cart_addr_w-1:0] a,
		input logic [be_w-1:0] be, input logic [data_w-1:0] wd, output logic [data_w-1:0] rd);
		exp_cmd.push_back(mem_addr_ref(p, we, a, be));
		do_req(p, we, a, be, wd, rd);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		port_id_e               p;
		logic                   we;
		logic [cart_addr_w-1:0] a;
		logic [cart_addr_w-1:0] saved_a [3];	// per client addresses for the priority test
		logic [data_w-1:0]      saved_v [3];
		logic [be_w-1:0]        be;
		logic [data_w-1:0]      wd;
		logic [data_w-1:0]      rd;
		logic [data_w-1:0]      old_w;
		logic [data_w-1:0]      exp_w;	// model word at the tested address
		logic [37:0]            cmd_ref;
		logic [mem_addr_w-1:0]  ram_a;
		logic [data_w-1:0]      rd_c;
		logic [data_w-1:0]      rd_w;
		logic [data_w-1:0]      rd_v;
		logic [9:0]             exp_pix;
		void'($urandom(32'h3d65_a14c));
		{errors, checks, tests_run, tests_failed, err_mark} = '0;
		CLK54 = 1'b0;
		RST_N = 1'b0;
		{cart_req, cart_addr} = '0;
		{work_req, work_we, work_addr, work_be, work_wdata} = '0;
		{vram_req, vram_we, vram_addr, vram_be, vram_wdata} = '0;
		{mem_cmd_ack, mem_rd_data, mem_rd_ack, mem_wr_ack} = '0;
		{pix_clk, pix_r, pix_g, pix_b, pix_hs, pix_vs, pix_de} = '0;
		{audio_l, audio_r, led_sel} = '0;
		repeat (8) @(posedge CLK54);
		#1;
		RST_N = 1'b1;

		check("cmd req and acks", {mem_cmd_req, cart_ack, work_ack, vram_ack}, '0);
		check("video outputs", {video_red, video_grn, video_blu, video_hsync, video_vsync}, '0);
		check("led", led, '0);
		test_done("reset values");

		for (int i = 0; i < 24; i++)
		begin
			p  = port_id_e'($urandom_range(0, 2));
			we = (p != port_cart) && ($urandom_range(0, 1) == 1);	// cartridge is read only
			a  = cart_addr_w'($urandom());
			be = be_w'($urandom());
			wd = $urandom();
			issue(p, we, a, be, wd, rd);
		end
		check("commands left unserved", exp_cmd.size(), 0);
		test_done("address map");

		for (int i = 1; i < 3; i++)
		begin
			p  = port_id_e'(i);
			a  = cart_addr_w'($urandom());
			be = be_w'($urandom());
			wd = $urandom();
			cmd_ref = mem_addr_ref(p, 1'b0, a, '0);
			ram_a   = cmd_ref[33:4];
			exp_w   = ram.exists(ram_a) ? ram[ram_a] : fill_word(ram_a, 1'b0);
			issue(p, 1'b0, a, '0, '0, old_w);
			check("ram before write", old_w, exp_w);
			issue(p, 1'b1, a, be, wd, rd);
			issue(p, 1'b0, a, '0, '0, rd);
			exp_w = byte_merge(exp_w, wd, be);	// bytes outside be keep old value
			check("ram readback", rd, exp_w);
			saved_a[i] = a;
			saved_v[i] = exp_w;
		end
		saved_a[0] = cart_addr_w'($urandom());
		cmd_ref    = mem_addr_ref(port_cart, 1'b0, saved_a[0], '0);
		saved_v[0] = fill_word(cmd_ref[33:4], 1'b1);
		issue(port_cart, 1'b0, saved_a[0], '0, '0, rd);
		check("flash read", rd, saved_v[0]);
		test_done("write and read");

		// same-cycle requests served in priority order
		ack_order.delete();
		exp_cmd.push_back(mem_addr_ref(port_cart, 1'b0, saved_a[0], '0));
		exp_cmd.push_back(mem_addr_ref(port_work, 1'b0, saved_a[1], '0));
		exp_cmd.push_back(mem_addr_ref(port_vram, 1'b0, saved_a[2], '0));
		fork
			do_req(port_cart, 1'b0, saved_a[0], '0, '0, rd_c);
			do_req(port_work, 1'b0, saved_a[1], '0, '0, rd_w);
			do_req(port_vram, 1'b0, saved_a[2], '0, '0, rd_v);
		join
		check("ack count", ack_order.size(), 3);
		for (int i = 0; i < ack_order.size(); i++)
			check("ack order", ack_order[i], i);
		check("cart data", rd_c, saved_v[0]);
		check("work data", rd_w, saved_v[1]);
		check("vram data", rd_v, saved_v[2]);
		test_done("priority");

		exp_pix = '0;
		for (int i = 0; i < 16; i++)
		begin
			pix_clk = 1'b0;
			{pix_r, pix_g, pix_b} = 24'($urandom());
			{pix_hs, pix_vs, pix_de} = 3'($urandom());
			for (int k = 0; k < 10; k++)
			begin
				if (k == 5)
				begin
					pix_clk = 1'b1;	// rising pixel edge
					exp_pix = pixel_ref(pix_r, pix_g, pix_b, pix_hs, pix_vs, pix_de);
				end
				@(posedge CLK54);
				#1;
				check("video out", {video_red, video_grn, video_blu, video_hsync, video_vsync},
					exp_pix);
			end
		end
		test_done("video sampler");

		for (int i = 0; i < 16; i++)
		begin
			audio_l = 16'($urandom());
			audio_r = 16'($urandom());
			led_sel = ~led_sel;
			for (int k = 1; k <= 4; k++)
			begin
				@(posedge CLK54);
				#1;
				if (k >= 2)	// two register stages
					check("led bar", led, led_ref(audio_l, audio_r, led_sel));
			end
		end
		test_done("level meter");

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* video_sampler.sv */
// pixel stream sampler
`timescale 1ns/1ps

module video_sampler import mg_pkg::*; (
	input  logic             CLK54,
	input  logic             RST_N,
	input  logic             pix_clk,	// console pixel clock, slow vs CLK54
	input  logic [pix_w-1:0] pix_r,
	input  logic [pix_w-1:0] pix_g,
	input  logic [pix_w-1:0] pix_b,
	input  logic             pix_hs,
	input  logic             pix_vs,
	input  logic             pix_de,	// display enable
	output logic [red_w-1:0] video_red,
	output logic [grn_w-1:0] video_grn,
	output logic [blu_w-1:0] video_blu,
	output logic             video_hsync,
	output logic             video_vsync
);

	logic pix_clk_q;	// previous pixel clock level
	logic pix_rise;	// one CLK54 cycle per pixel

	assign pix_rise = pix_clk & ~pix_clk_q;

	// ----------------------------------------
	// capture one pixel per rising edge
	// ----------------------------------------
	always_ff @(posedge CLK54 or negedge RST_N)
	begin
		if (!RST_N)
		begin
			pix_clk_q   <= 1'b0;
			video_red   <= '0;
			video_grn   <= '0;
			video_blu   <= '0;
			video_hsync <= 1'b0;
			video_vsync <= 1'b0;
		end
		else
		begin
			pix_clk_q <= pix_clk;
			if (pix_rise)
			begin
				// top bits only, black outside active area
				video_red   <= pix_de ? pix_r[pix_w-1 -: red_w] : '0;
				video_grn   <= pix_de ? pix_g[pix_w-1 -: grn_w] : '0;
				video_blu   <= pix_de ? pix_b[pix_w-1 -: blu_w] : '0;
				video_hsync <= pix_hs;	// syncs pass regardless of de
				video_vsync <= pix_vs;
			end
		end
	end

endmodule
